// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   localparam int PADDR_W  = 12;
   localparam int OFFSET_W = 3;
   localparam int INDEX_W  = 3;
   localparam int TAG_W    = PADDR_W - INDEX_W - OFFSET_W;

   // Direct mapped, one dword per line
   localparam int SETS = 1 << INDEX_W;

   typedef enum logic [1:0] {
      OP_LD_D  = 2'd0,
      OP_LD_WU = 2'd1,
      OP_SD    = 2'd2,
      OP_SW    = 2'd3
   } dcache_op_e;

   typedef logic [PADDR_W-1:0] paddr_t;
   typedef logic [63:0]        dword_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [TAG_W-1:0]   tag_t;

endpackage

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

   // Memory serves both read kinds the same way
   typedef enum logic [1:0] {
      MEM_READ    = 2'd0,
      MEM_UC_READ = 2'd1,
      MEM_WRITE   = 2'd2
   } mem_cmd_e;

   typedef enum logic {
      MEM_WORD  = 1'b0,
      MEM_DWORD = 1'b1
   } mem_size_e;

   // Up to 7 commands in flight
   typedef logic [2:0] credit_t;

endpackage

`default_nettype wire

// File: rollback_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module rollback_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   enq_v_i,
   input  dcache_pkg::dcache_op_e op_i,
   input  logic                   uncached_i,
   input  dcache_pkg::paddr_t     addr_i,
   input  dcache_pkg::dword_t     data_i,
   output logic                   ready_o,
   output logic                   v_o,
   output dcache_pkg::dcache_op_e op_o,
   output logic                   uncached_o,
   output dcache_pkg::paddr_t     addr_o,
   output dcache_pkg::dword_t     data_o,
   input  logic                   yumi_i,
   input  logic                   commit_i,
   input  logic                   roll_i
);

   import dcache_pkg::*;

   // Pointers carry one wrap bit over a power-of-two depth
   localparam int PTR_W = $clog2(FIFO_DEPTH);

   typedef logic [PTR_W:0] ptr_t;

   dcache_op_e op_mem   [FIFO_DEPTH];
   logic       uc_mem   [FIFO_DEPTH];
   paddr_t     addr_mem [FIFO_DEPTH];
   dword_t     data_mem [FIFO_DEPTH];

   ptr_t wptr_q;
   ptr_t rptr_q;
   ptr_t cptr_q;
   ptr_t held;
   logic enq;

   // Entries read but not committed still count
   assign held    = wptr_q - cptr_q;
   assign ready_o = (held != ptr_t'(FIFO_DEPTH));
   assign enq     = enq_v_i & ready_o;
   assign v_o     = (rptr_q != wptr_q);

   assign op_o       = op_mem[rptr_q[PTR_W-1:0]];
   assign uncached_o = uc_mem[rptr_q[PTR_W-1:0]];
   assign addr_o     = addr_mem[rptr_q[PTR_W-1:0]];
   assign data_o     = data_mem[rptr_q[PTR_W-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         op_mem[wptr_q[PTR_W-1:0]]   <= op_i;
         uc_mem[wptr_q[PTR_W-1:0]]   <= uncached_i;
         addr_mem[wptr_q[PTR_W-1:0]] <= addr_i;
         data_mem[wptr_q[PTR_W-1:0]] <= data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wptr_q <= '0;
         rptr_q <= '0;
         cptr_q <= '0;
      end
      else
      begin
         if (enq)
            wptr_q <= wptr_q + ptr_t'(1);
         if (commit_i)
            cptr_q <= cptr_q + ptr_t'(1);
         // An uncached load commits after rewind without being read again
         if (roll_i)
            rptr_q <= cptr_q;
         else if (yumi_i || (commit_i && rptr_q == cptr_q))
            rptr_q <= rptr_q + ptr_t'(1);
      end
   end

   // Commit only frees an entry that was taken
   a_commit_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      commit_i |-> (cptr_q != wptr_q));

   // Speculative reads stay within the held entries
   a_read_in_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ptr_t'(rptr_q - cptr_q) <= held);

endmodule

`default_nettype wire

// File: dcache_core.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_core (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   fifo_v_i,
   input  dcache_pkg::dcache_op_e op_i,
   input  logic                   uncached_i,
   input  dcache_pkg::paddr_t     addr_i,
   input  dcache_pkg::dword_t     data_i,
   output logic                   fifo_yumi_o,
   output logic                   commit_o,
   output logic                   roll_o,
   output logic                   resp_v_o,
   output dcache_pkg::dword_t     resp_data_o,
   output logic                   eng_req_v_o,
   output mem_pkg::mem_cmd_e      eng_req_kind_o,
   output mem_pkg::mem_size_e     eng_req_size_o,
   output dcache_pkg::paddr_t     eng_req_addr_o,
   output dcache_pkg::dword_t     eng_req_data_o,
   input  logic                   eng_req_ack_i,
   input  logic                   eng_busy_i,
   input  logic                   fill_v_i,
   input  dcache_pkg::index_t     fill_index_i,
   input  dcache_pkg::tag_t       fill_tag_i,
   input  dcache_pkg::dword_t     fill_data_i,
   input  logic                   uc_v_i,
   input  dcache_pkg::dword_t     uc_data_i
);

   import dcache_pkg::*;
   import mem_pkg::*;

   logic [SETS-1:0] valid_q;
   tag_t            tag_mem  [SETS];
   dword_t          data_mem [SETS];

   index_t     s1_index;
   logic       s2_v_q;
   dcache_op_e s2_op_q;
   logic       s2_uc_q;
   paddr_t     s2_addr_q;
   dword_t     s2_data_q;
   logic       s2_valid_q;
   tag_t       s2_tag_q;
   dword_t     s2_line_q;

   index_t s2_index;
   tag_t   s2_addr_tag;
   logic   s2_load;
   logic   hit;
   logic   load_hit;
   logic   store_done;
   logic   complete;
   dword_t merged;

   function automatic dword_t load_format(dcache_op_e op, logic upper, dword_t d);
      dword_t r;
      if (op == OP_LD_WU)
         r = {32'b0, upper ? d[63:32] : d[31:0]};
      else
         r = d;
      return r;
   endfunction

   // No lookup while the engine takes or serves a request
   assign s1_index    = addr_i[OFFSET_W +: INDEX_W];
   assign fifo_yumi_o = fifo_v_i & ~roll_o & ~eng_busy_i & ~eng_req_ack_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         s2_v_q <= 1'b0;
      else
         s2_v_q <= fifo_yumi_o;
   end

   always_ff @(posedge clk_i)
   begin
      if (fifo_yumi_o)
      begin
         s2_op_q    <= op_i;
         s2_uc_q    <= uncached_i;
         s2_addr_q  <= addr_i;
         s2_data_q  <= data_i;
         s2_valid_q <= valid_q[s1_index];
         s2_tag_q   <= tag_mem[s1_index];
         s2_line_q  <= data_mem[s1_index];
      end
   end

   assign s2_index    = s2_addr_q[OFFSET_W +: INDEX_W];
   assign s2_addr_tag = s2_addr_q[PADDR_W-1 -: TAG_W];
   assign s2_load     = (s2_op_q == OP_LD_D) || (s2_op_q == OP_LD_WU);
   assign hit         = s2_valid_q && (s2_tag_q == s2_addr_tag);
   assign load_hit    = s2_v_q && s2_load && !s2_uc_q && hit;
   assign store_done  = s2_v_q && !s2_load && eng_req_ack_i;
   assign complete    = load_hit || store_done;

   assign roll_o   = s2_v_q && !complete;
   assign resp_v_o = complete || uc_v_i;
   assign commit_o = resp_v_o;

   // Stage 2 payload is held while the engine serves an uncached load
   always_comb
   begin
      if (uc_v_i)
         resp_data_o = load_format(s2_op_q, s2_addr_q[2], uc_data_i);
      else if (s2_load)
         resp_data_o = load_format(s2_op_q, s2_addr_q[2], s2_line_q);
      else
         resp_data_o = '0;
   end

   always_comb
   begin
      merged = s2_line_q;
      if (s2_op_q == OP_SD)
         merged = s2_data_q;
      else if (s2_addr_q[2])
         merged[63:32] = s2_data_q[31:0];
      else
         merged[31:0] = s2_data_q[31:0];
   end

   // Reads fetch the whole aligned dword
   assign eng_req_v_o    = s2_v_q && !load_hit;
   assign eng_req_kind_o = !s2_load ? MEM_WRITE : (s2_uc_q ? MEM_UC_READ : MEM_READ);
   assign eng_req_size_o = (s2_op_q == OP_SW) ? MEM_WORD : MEM_DWORD;
   assign eng_req_addr_o = s2_load ? {s2_addr_q[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}
                                   : s2_addr_q;
   assign eng_req_data_o = s2_data_q;

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
      begin
         tag_mem[fill_index_i]  <= fill_tag_i;
         data_mem[fill_index_i] <= fill_data_i;
      end
      else if (store_done && hit)
         data_mem[s2_index] <= merged;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         valid_q <= '0;
      else if (fill_v_i)
         valid_q[fill_index_i] <= 1'b1;
   end

   // Engine results never land on a pending lookup
   a_commit_roll: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(commit_o && roll_o));

endmodule

`default_nettype wire

// File: uncached_engine.sv
`timescale 1ns/10ps
`default_nettype none

module uncached_engine #(
   parameter int MEM_CREDITS = 4
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               eng_req_v_i,
   input  mem_pkg::mem_cmd_e  eng_req_kind_i,
   input  mem_pkg::mem_size_e eng_req_size_i,
   input  dcache_pkg::paddr_t eng_req_addr_i,
   input  dcache_pkg::dword_t eng_req_data_i,
   output logic               eng_req_ack_o,
   output logic               eng_busy_o,
   output logic               fill_v_o,
   output dcache_pkg::index_t fill_index_o,
   output dcache_pkg::tag_t   fill_tag_o,
   output dcache_pkg::dword_t fill_data_o,
   output logic               uc_v_o,
   output dcache_pkg::dword_t uc_data_o,
   output logic               mem_cmd_v_o,
   output mem_pkg::mem_cmd_e  mem_cmd_kind_o,
   output mem_pkg::mem_size_e mem_cmd_size_o,
   output dcache_pkg::paddr_t mem_cmd_addr_o,
   output dcache_pkg::dword_t mem_cmd_data_o,
   input  logic               mem_cmd_ready_i,
   input  logic               mem_resp_v_i,
   input  dcache_pkg::dword_t mem_resp_data_i
);

   import dcache_pkg::*;
   import mem_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEND,
      ST_WAIT
   } state_e;

   state_e    state_q;
   credit_t   credits_q;
   mem_cmd_e  kind_q;
   mem_size_e size_q;
   paddr_t    addr_q;
   dword_t    data_q;
   logic      cmd_fire;
   logic      read_done;

   assign eng_req_ack_o = eng_req_v_i && (state_q == ST_IDLE) && (credits_q != '0);
   assign eng_busy_o    = (state_q != ST_IDLE);

   assign mem_cmd_v_o    = (state_q == ST_SEND) && (credits_q != '0);
   assign mem_cmd_kind_o = kind_q;
   assign mem_cmd_size_o = size_q;
   assign mem_cmd_addr_o = addr_q;
   assign mem_cmd_data_o = data_q;
   assign cmd_fire       = mem_cmd_v_o && mem_cmd_ready_i;

   // In-order responses, so the read answer is the last one outstanding
   assign read_done = (state_q == ST_WAIT) && mem_resp_v_i
                      && (credits_q == credit_t'(MEM_CREDITS - 1));

   assign fill_v_o     = read_done && (kind_q == MEM_READ);
   assign fill_index_o = addr_q[OFFSET_W +: INDEX_W];
   assign fill_tag_o   = addr_q[PADDR_W-1 -: TAG_W];
   assign fill_data_o  = mem_resp_data_i;
   assign uc_v_o       = read_done && (kind_q == MEM_UC_READ);
   assign uc_data_o    = mem_resp_data_i;

   always_ff @(posedge clk_i)
   begin
      if (eng_req_ack_o)
      begin
         kind_q <= eng_req_kind_i;
         size_q <= eng_req_size_i;
         addr_q <= eng_req_addr_i;
         data_q <= eng_req_data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         credits_q <= credit_t'(MEM_CREDITS);
      else
         credits_q <= credits_q + credit_t'(mem_resp_v_i) - credit_t'(cmd_fire);
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         state_q <= ST_IDLE;
      else
      begin
         case (state_q)
            ST_IDLE:
               if (eng_req_ack_o)
                  state_q <= ST_SEND;
            // Writes retire on issue
            ST_SEND:
               if (cmd_fire)
                  state_q <= (kind_q == MEM_WRITE) ? ST_IDLE : ST_WAIT;
            ST_WAIT:
               if (read_done)
                  state_q <= ST_IDLE;
            default:
               state_q <= ST_IDLE;
         endcase
      end
   end

   a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credits_q <= credit_t'(MEM_CREDITS));

   // Memory answers only commands in flight
   a_resp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_resp_v_i |-> (credits_q != credit_t'(MEM_CREDITS)));

endmodule

`default_nettype wire

// File: dcache_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_wrapper #(
   parameter int FIFO_DEPTH  = 8,
   parameter int MEM_CREDITS = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   req_v_i,
   input  dcache_pkg::dcache_op_e req_op_i,
   input  logic                   req_uncached_i,
   input  dcache_pkg::paddr_t     req_addr_i,
   input  dcache_pkg::dword_t     req_data_i,
   output logic                   req_ready_o,
   output logic                   resp_v_o,
   output dcache_pkg::dword_t     resp_data_o,
   output logic                   mem_cmd_v_o,
   output mem_pkg::mem_cmd_e      mem_cmd_kind_o,
   output mem_pkg::mem_size_e     mem_cmd_size_o,
   output dcache_pkg::paddr_t     mem_cmd_addr_o,
   output dcache_pkg::dword_t     mem_cmd_data_o,
   input  logic                   mem_cmd_ready_i,
   input  logic                   mem_resp_v_i,
   input  dcache_pkg::dword_t     mem_resp_data_i
);

   import dcache_pkg::*;
   import mem_pkg::*;

   // FIFO to core
   logic       fifo_v;
   dcache_op_e fifo_op;
   logic       fifo_uc;
   paddr_t     fifo_addr;
   dword_t     fifo_data;
   logic       fifo_yumi;
   logic       commit;
   logic       roll;

   // Core to engine
   logic      eng_req_v;
   mem_cmd_e  eng_req_kind;
   mem_size_e eng_req_size;
   paddr_t    eng_req_addr;
   dword_t    eng_req_data;
   logic      eng_req_ack;
   logic      eng_busy;
   logic      fill_v;
   index_t    fill_index;
   tag_t      fill_tag;
   dword_t    fill_data;
   logic      uc_v;
   dword_t    uc_data;

   rollback_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .enq_v_i    (req_v_i),
      .op_i       (req_op_i),
      .uncached_i (req_uncached_i),
      .addr_i     (req_addr_i),
      .data_i     (req_data_i),
      .ready_o    (req_ready_o),
      .v_o        (fifo_v),
      .op_o       (fifo_op),
      .uncached_o (fifo_uc),
      .addr_o     (fifo_addr),
      .data_o     (fifo_data),
      .yumi_i     (fifo_yumi),
      .commit_i   (commit),
      .roll_i     (roll)
   );

   dcache_core i_core (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .fifo_v_i       (fifo_v),
      .op_i           (fifo_op),
      .uncached_i     (fifo_uc),
      .addr_i         (fifo_addr),
      .data_i         (fifo_data),
      .fifo_yumi_o    (fifo_yumi),
      .commit_o       (commit),
      .roll_o         (roll),
      .resp_v_o       (resp_v_o),
      .resp_data_o    (resp_data_o),
      .eng_req_v_o    (eng_req_v),
      .eng_req_kind_o (eng_req_kind),
      .eng_req_size_o (eng_req_size),
      .eng_req_addr_o (eng_req_addr),
      .eng_req_data_o (eng_req_data),
      .eng_req_ack_i  (eng_req_ack),
      .eng_busy_i     (eng_busy),
      .fill_v_i       (fill_v),
      .fill_index_i   (fill_index),
      .fill_tag_i     (fill_tag),
      .fill_data_i    (fill_data),
      .uc_v_i         (uc_v),
      .uc_data_i      (uc_data)
   );

   uncached_engine #(
      .MEM_CREDITS (MEM_CREDITS)
   ) i_engine (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .eng_req_v_i     (eng_req_v),
      .eng_req_kind_i  (eng_req_kind),
      .eng_req_size_i  (eng_req_size),
      .eng_req_addr_i  (eng_req_addr),
      .eng_req_data_i  (eng_req_data),
      .eng_req_ack_o   (eng_req_ack),
      .eng_busy_o      (eng_busy),
      .fill_v_o        (fill_v),
      .fill_index_o    (fill_index),
      .fill_tag_o      (fill_tag),
      .fill_data_o     (fill_data),
      .uc_v_o          (uc_v),
      .uc_data_o       (uc_data),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_kind_o  (mem_cmd_kind_o),
      .mem_cmd_size_o  (mem_cmd_size_o),
      .mem_cmd_addr_o  (mem_cmd_addr_o),
      .mem_cmd_data_o  (mem_cmd_data_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_data_i (mem_resp_data_i)
   );

endmodule

`default_nettype wire

// File: tb_dcache_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_wrapper;

   import dcache_pkg::*;
   import mem_pkg::*;

   localparam int          FIFO_DEPTH      = 8;
   localparam int          MEM_CREDITS     = 4;
   localparam int          HALF_PERIOD     = 2;
   localparam int          DRIVE_DLY       = 1;
   localparam int          RST_CYCLES      = 8;
   localparam int          NUM_LINES       = 32;
   localparam int          IDX_W           = $clog2(NUM_LINES);
   localparam int          CYCLES_PER_LINE = 200;
   localparam int          TIMEOUT_CYCLES  = RST_CYCLES + NUM_LINES * CYCLES_PER_LINE;
   localparam int          MEM_DWORDS      = 512;
   localparam logic [31:0] SEED            = 32'hfb27_d3d1;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       req_v;
   dcache_op_e req_op;
   logic       req_uncached;
   paddr_t     req_addr;
   dword_t     req_data;
   logic       req_ready;
   logic       resp_v;
   dword_t     resp_data;
   logic       mem_cmd_v;
   mem_cmd_e   mem_cmd_kind;
   mem_size_e  mem_cmd_size;
   paddr_t     mem_cmd_addr;
   dword_t     mem_cmd_data;
   logic       mem_cmd_ready;
   logic       mem_resp_v;
   dword_t     mem_resp_data;

   // Trace line: behavior, op, uncached, addr, store data, expected result
   logic [151:0] trace_mem [NUM_LINES];
   dword_t       mem_model [MEM_DWORDS];
   dword_t       resp_q [$];
   int unsigned  head_wait = 0;
   int           resp_count = 0;
   int           cycle_count = 0;

   dcache_wrapper #(
      .FIFO_DEPTH  (FIFO_DEPTH),
      .MEM_CREDITS (MEM_CREDITS)
   ) i_dut (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .req_v_i         (req_v),
      .req_op_i        (req_op),
      .req_uncached_i  (req_uncached),
      .req_addr_i      (req_addr),
      .req_data_i      (req_data),
      .req_ready_o     (req_ready),
      .resp_v_o        (resp_v),
      .resp_data_o     (resp_data),
      .mem_cmd_v_o     (mem_cmd_v),
      .mem_cmd_kind_o  (mem_cmd_kind),
      .mem_cmd_size_o  (mem_cmd_size),
      .mem_cmd_addr_o  (mem_cmd_addr),
      .mem_cmd_data_o  (mem_cmd_data),
      .mem_cmd_ready_i (mem_cmd_ready),
      .mem_resp_v_i    (mem_resp_v),
      .mem_resp_data_i (mem_resp_data)
   );

   always #(HALF_PERIOD) clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input dword_t expected, input dword_t actual);
      if (actual !== expected)
         abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
   endtask

   function automatic string line_name(input int idx);
      return $sformatf("behavior %0d line %0d", trace_mem[IDX_W'(idx)][151:148], idx);
   endfunction

   // Memory slows down while the store burst is in flight
   function automatic logic slow_mem();
      return (resp_count < NUM_LINES) && (trace_mem[IDX_W'(resp_count)][151:148] == 4'd5);
   endfunction

   function automatic int unsigned resp_delay();
      if (slow_mem())
         return 6;
      return $urandom_range(6, 1);
   endfunction

   task automatic exec_mem_cmd();
      dword_t cur;
      cur = mem_model[mem_cmd_addr[11:3]];
      if (resp_q.size() == 0)
         head_wait = resp_delay();
      if (mem_cmd_kind == MEM_WRITE)
      begin
         if (mem_cmd_size == MEM_DWORD)
            cur = mem_cmd_data;
         else if (mem_cmd_addr[2])
            cur[63:32] = mem_cmd_data[31:0];
         else
            cur[31:0] = mem_cmd_data[31:0];
         mem_model[mem_cmd_addr[11:3]] = cur;
         resp_q.push_back('0);
      end
      else
         resp_q.push_back(cur);
   endtask

   task automatic send_request(input int idx);
      req_v        = 1'b1;
      req_op       = dcache_op_e'(trace_mem[IDX_W'(idx)][145:144]);
      req_uncached = trace_mem[IDX_W'(idx)][140];
      req_addr     = trace_mem[IDX_W'(idx)][139:128];
      req_data     = trace_mem[IDX_W'(idx)][127:64];
      @(negedge clk);
      while (!req_ready)
         @(negedge clk);
      @(posedge clk);
      #(DRIVE_DLY);
      req_v = 1'b0;
   endtask

   // Memory model, commands sampled at the falling edge
   initial
   begin
      mem_cmd_ready = 1'b0;
      mem_resp_v    = 1'b0;
      mem_resp_data = '0;
      for (int i = 0; i < MEM_DWORDS; i++)
         mem_model[9'(i)] = {16'hda7a, 7'd0, 9'(i), 16'h5eed, 7'd0, 9'(i)};
      forever
      begin
         @(negedge clk);
         if (rst_n && mem_cmd_v && mem_cmd_ready)
            exec_mem_cmd();
         @(posedge clk);
         #(DRIVE_DLY);
         mem_resp_v = 1'b0;
         if (resp_q.size() > 0)
         begin
            if (head_wait > 1)
               head_wait--;
            else
            begin
               mem_resp_v    = 1'b1;
               mem_resp_data = resp_q.pop_front();
               head_wait     = resp_delay();
            end
         end
         if (slow_mem())
            mem_cmd_ready = ($urandom_range(1) == 0);
         else
            mem_cmd_ready = ($urandom_range(3) != 0);
      end
   end

   always @(negedge clk)
   begin
      if (rst_n && resp_v)
      begin
         if (resp_count >= NUM_LINES)
            abort_run("A result arrived after every trace line had its result");
         else
         begin
            check_value(line_name(resp_count), trace_mem[IDX_W'(resp_count)][63:0], resp_data);
            resp_count <= resp_count + 1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results",
                             cycle_count, resp_count, NUM_LINES));
   end

   initial
   begin
      int unsigned gap;
      rst_n        = 1'b0;
      req_v        = 1'b0;
      req_op       = OP_LD_D;
      req_uncached = 1'b0;
      req_addr     = '0;
      req_data     = '0;
      void'($urandom(SEED));
      $readmemh("dcache_testdata.hex", trace_mem);
      repeat (RST_CYCLES) @(posedge clk);
      #(DRIVE_DLY);
      rst_n = 1'b1;
      for (int i = 0; i < NUM_LINES; i++)
      begin
         // Store burst goes back to back
         if (trace_mem[IDX_W'(i)][151:148] == 4'd5)
            gap = 0;
         else
            gap = $urandom_range(3);
         repeat (gap)
         begin
            @(posedge clk);
            #(DRIVE_DLY);
         end
         send_request(i);
      end
      wait (resp_count == NUM_LINES);
      repeat (20) @(posedge clk);
      if (resp_count == NUM_LINES && resp_q.size() == 0)
      begin
         $display("*** PASSED ***");
         $finish;
      end
      else
         abort_run($sformatf("Run ended with %0d of %0d results and %0d memory responses left",
                             resp_count, NUM_LINES, resp_q.size()));
   end

endmodule

`default_nettype wire

// File: dcache_testdata.hex
// behavior _ op _ uncached _ addr _ store data _ expected result
// op: 0 load dword, 1 load word unsigned, 2 store dword, 3 store word
1_0_0_040_0000000000000000_da7a00085eed0008
1_0_0_040_0000000000000000_da7a00085eed0008
2_2_0_040_1122334455667788_0000000000000000
2_0_0_040_0000000000000000_1122334455667788
2_3_0_0c4_00000000cafef00d_0000000000000000
2_0_0_0c0_0000000000000000_cafef00d5eed0018
2_3_0_040_00000000a5a5a5a5_0000000000000000
2_0_0_040_0000000000000000_11223344a5a5a5a5
2_3_0_044_000000000f0f0f0f_0000000000000000
2_0_0_040_0000000000000000_0f0f0f0fa5a5a5a5
3_0_1_108_0000000000000000_da7a00215eed0021
3_0_0_108_0000000000000000_da7a00215eed0021
3_2_0_108_0badc0de12345678_0000000000000000
3_0_1_108_0000000000000000_0badc0de12345678
3_1_1_10c_0000000000000000_000000000badc0de
4_0_0_010_0000000000000000_da7a00025eed0002
4_0_0_250_0000000000000000_da7a004a5eed004a
4_0_0_010_0000000000000000_da7a00025eed0002
4_0_0_250_0000000000000000_da7a004a5eed004a
5_2_0_300_5000000000000001_0000000000000000
5_2_0_308_5000000000000002_0000000000000000
5_2_0_310_5000000000000003_0000000000000000
5_2_0_318_5000000000000004_0000000000000000
5_2_0_320_5000000000000005_0000000000000000
5_3_0_32c_0000000077777777_0000000000000000
5_0_0_300_0000000000000000_5000000000000001
5_0_0_318_0000000000000000_5000000000000004
5_0_0_328_0000000000000000_777777775eed0065
5_0_0_320_0000000000000000_5000000000000005
6_1_0_044_0000000000000000_000000000f0f0f0f
6_1_0_250_0000000000000000_000000005eed004a
6_1_1_104_0000000000000000_00000000da7a0020

// File: all.f
dcache_pkg.sv
mem_pkg.sv
rollback_fifo.sv
dcache_core.sv
uncached_engine.sv
dcache_wrapper.sv
tb_dcache_wrapper.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_wrapper
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then echo "Test passed"; \
	else echo "Test failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
